//--- build.f
src/vmul_cfg_pkg.sv
src/vmul_types_pkg.sv
src/mul_req_if.sv
src/vinsn_queue.sv
src/mul_issue.sv
src/simd_mul.sv
src/result_stage.sv
src/vmul_unit.sv
tb/vmul_checker.sv
tb/vmul_properties.sv
tb/tb_vmul_unit.sv

//--- src/mul_issue.sv
// Issue control; queue 0 is vs1, queue 1 is vs2, queue 2 is vd, and every element is active
`timescale 1ns/1ps

module mul_issue (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  vmul_types_pkg::vinsn_t                  insn_i,
  input  logic                                    insn_valid_i,
  output logic                                    done_o,
  input  logic [2:0][vmul_cfg_pkg::ElenWidth-1:0] operand_i,
  input  logic [2:0]                              operand_valid_i,
  output logic [2:0]                              operand_ready_o,
  mul_req_if.issue                                mul
);

  logic [vmul_cfg_pkg::VlWidth-1:0]   rem_q, rem_cur, rem_next;
  logic                               busy_q;
  logic [vmul_cfg_pkg::ElenWidth-1:0] scalar_rep;
  logic [2:0]                         needed;
  logic                               fire;

  // A new instruction starts from its full vector length
  assign rem_cur  = busy_q ? rem_q : insn_i.vl;
  assign rem_next = rem_cur - vmul_types_pkg::word_elems(insn_i.vew, rem_cur);

  // Copy the scalar into every element of the word
  always_comb begin
    scalar_rep = insn_i.scalar;
    case (insn_i.vew)
      vmul_types_pkg::EW8:  scalar_rep = {8{insn_i.scalar[7:0]}};
      vmul_types_pkg::EW16: scalar_rep = {4{insn_i.scalar[15:0]}};
      vmul_types_pkg::EW32: scalar_rep = {2{insn_i.scalar[31:0]}};
      default: ;
    endcase
  end

  // vd is read only for the multiply-accumulate
  assign needed = {insn_i.op == vmul_types_pkg::VMACC, 1'b1, !insn_i.use_scalar};

  assign mul.operand_a = insn_i.use_scalar ? scalar_rep : operand_i[0];
  assign mul.operand_b = operand_i[1];
  assign mul.operand_c = operand_i[2];
  assign mul.op        = insn_i.op;
  assign mul.vew       = insn_i.vew;
  assign mul.valid     = insn_valid_i && (&(operand_valid_i | ~needed));

  assign fire            = mul.valid && mul.ready;
  assign operand_ready_o = fire ? needed : 3'b000;
  assign done_o          = fire && (rem_next == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      rem_q  <= '0;
    end else if (fire) begin
      busy_q <= (rem_next != '0);
      rem_q  <= rem_next;
    end
  end

endmodule

//--- src/mul_req_if.sv
// One micro-operation moves on each edge with valid and ready high; operands are raw words
`timescale 1ns/1ps

interface mul_req_if;

  logic [vmul_cfg_pkg::ElenWidth-1:0] operand_a;
  logic [vmul_cfg_pkg::ElenWidth-1:0] operand_b;
  logic [vmul_cfg_pkg::ElenWidth-1:0] operand_c;
  vmul_types_pkg::vmul_op_e           op;
  vmul_types_pkg::vew_e               vew;
  logic                               valid;
  logic                               ready;

  modport issue (
    output operand_a, operand_b, operand_c, op, vew, valid,
    input  ready
  );

  modport mul (
    input  operand_a, operand_b, operand_c, op, vew, valid,
    output ready
  );

endinterface

//--- src/result_stage.sv
// Write-back; results arrive in instruction order and the VRF grants only the queue head
`timescale 1ns/1ps

module result_stage (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic [vmul_cfg_pkg::ElenWidth-1:0]  result_i,
  input  logic                                valid_i,
  output logic                                ready_o,
  input  vmul_types_pkg::vinsn_t              proc_insn_i,
  input  logic                                proc_valid_i,
  output logic                                proc_done_o,
  input  vmul_types_pkg::vinsn_t              commit_insn_i,
  input  logic                                commit_valid_i,
  output logic                                commit_done_o,
  output logic [vmul_cfg_pkg::NrVInsn-1:0]    vinsn_done_o,
  output logic                                result_req_o,
  output logic [vmul_cfg_pkg::VidWidth-1:0]   result_id_o,
  output logic [vmul_cfg_pkg::VaddrWidth-1:0] result_addr_o,
  output logic [vmul_cfg_pkg::ElenWidth-1:0]  result_wdata_o,
  output logic [vmul_cfg_pkg::StrbWidth-1:0]  result_be_o,
  input  logic                                result_gnt_i
);

  localparam int unsigned Depth = vmul_cfg_pkg::ResultQueueDepth;
  localparam int unsigned PtrW  = $clog2(Depth);

  typedef logic [vmul_cfg_pkg::VlWidth-1:0]    cnt_t;
  typedef logic [vmul_cfg_pkg::VaddrWidth-1:0] addr_t;
  typedef logic [vmul_cfg_pkg::StrbWidth-1:0]  strb_t;

  typedef struct packed {
    logic [vmul_cfg_pkg::VidWidth-1:0]  id;
    addr_t                              addr;
    logic [vmul_cfg_pkg::ElenWidth-1:0] wdata;
    strb_t                              be;
  } entry_t;

  entry_t          queue_q [Depth];
  entry_t          new_entry;
  logic [PtrW-1:0] wr_pnt_q, rd_pnt_q;
  logic [PtrW:0]   fill_q;
  logic            push, pop;
  cnt_t            proc_rem_q, proc_cur, proc_elems, proc_next, word_idx;
  cnt_t            commit_rem_q, commit_cur, commit_next;
  logic            proc_busy_q, commit_busy_q;

  assign ready_o = proc_valid_i && (fill_q != (PtrW+1)'(Depth));
  assign push    = valid_i && ready_o;
  assign pop     = result_req_o && result_gnt_i;

  assign proc_cur    = proc_busy_q ? proc_rem_q : proc_insn_i.vl;
  assign proc_elems  = vmul_types_pkg::word_elems(proc_insn_i.vew, proc_cur);
  assign proc_next   = proc_cur - proc_elems;
  assign proc_done_o = push && (proc_next == '0);

  // Words already produced give the offset inside the destination register
  assign word_idx = (proc_insn_i.vl - proc_cur) >> (2'd3 - proc_insn_i.vew);

  assign new_entry = '{
    id:    proc_insn_i.id,
    addr:  addr_t'(int'(proc_insn_i.vd) * vmul_cfg_pkg::RegWords + int'(word_idx)),
    wdata: result_i,
    be:    strb_t'((1 << (int'(proc_elems) << int'(proc_insn_i.vew))) - 1)
  };

  assign commit_cur    = commit_busy_q ? commit_rem_q : commit_insn_i.vl;
  assign commit_next   = commit_cur - vmul_types_pkg::word_elems(commit_insn_i.vew, commit_cur);
  assign commit_done_o = pop && commit_valid_i && (commit_next == '0);

  always_comb begin
    vinsn_done_o = '0;
    vinsn_done_o[commit_insn_i.id] = commit_done_o;
  end

  // Request stays up with the head entry until the grant
  assign result_req_o   = (fill_q != '0);
  assign result_id_o    = queue_q[rd_pnt_q].id;
  assign result_addr_o  = queue_q[rd_pnt_q].addr;
  assign result_wdata_o = queue_q[rd_pnt_q].wdata;
  assign result_be_o    = queue_q[rd_pnt_q].be;

  always_ff @(posedge clk_i) begin
    if (push) begin
      queue_q[wr_pnt_q] <= new_entry;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q      <= '0;
      rd_pnt_q      <= '0;
      fill_q        <= '0;
      proc_busy_q   <= 1'b0;
      proc_rem_q    <= '0;
      commit_busy_q <= 1'b0;
      commit_rem_q  <= '0;
    end else begin
      if (push) begin
        wr_pnt_q    <= wr_pnt_q + PtrW'(1);
        proc_busy_q <= (proc_next != '0);
        proc_rem_q  <= proc_next;
      end
      if (pop) begin
        rd_pnt_q <= rd_pnt_q + PtrW'(1);
      end
      if (pop && commit_valid_i) begin
        commit_busy_q <= (commit_next != '0);
        commit_rem_q  <= commit_next;
      end
      fill_q <= fill_q + (PtrW+1)'(push) - (PtrW+1)'(pop);
    end
  end

endmodule

//--- src/simd_mul.sv
// SIMD multiplier; VMULH is signed by signed and MulLatency must be 1 or more
`timescale 1ns/1ps

module simd_mul #(
  parameter int unsigned MulLatency = vmul_cfg_pkg::MulLatencyDefault
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  mul_req_if.mul                             req,
  output logic [vmul_cfg_pkg::ElenWidth-1:0] result_o,
  output logic                               valid_o,
  input  logic                               ready_i
);

  localparam int unsigned Elen = vmul_cfg_pkg::ElenWidth;

  // One candidate word per element width
  logic [3:0][Elen-1:0]  ew_result;
  logic [Elen-1:0]       stage_data [MulLatency];
  logic [MulLatency-1:0] stage_valid;
  logic                  advance;

  for (genvar e = 0; e < 4; e++) begin : gen_ew
    localparam int unsigned W = 8 << e;
    for (genvar i = 0; i < Elen / W; i++) begin : gen_elem
      logic signed [W-1:0]   a;
      logic signed [W-1:0]   b;
      logic        [W-1:0]   c;
      logic signed [2*W-1:0] prod;

      assign a    = req.operand_a[W*i +: W];
      assign b    = req.operand_b[W*i +: W];
      assign c    = req.operand_c[W*i +: W];
      assign prod = a * b;

      assign ew_result[e][W*i +: W] =
          (req.op == vmul_types_pkg::VMULH) ? prod[2*W-1:W] :
          (req.op == vmul_types_pkg::VMACC) ? prod[W-1:0] + c : prod[W-1:0];
    end
  end

  // All stages move together, so a held output stalls the whole chain
  assign advance   = !stage_valid[MulLatency-1] || ready_i;
  assign req.ready = advance;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stage_valid <= '0;
    end else if (advance) begin
      stage_valid[0] <= req.valid;
      for (int s = 1; s < MulLatency; s++) begin
        stage_valid[s] <= stage_valid[s-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance) begin
      stage_data[0] <= ew_result[req.vew];
      for (int s = 1; s < MulLatency; s++) begin
        stage_data[s] <= stage_data[s-1];
      end
    end
  end

  assign result_o = stage_data[MulLatency-1];
  assign valid_o  = stage_valid[MulLatency-1];

endmodule

//--- src/vinsn_queue.sv
// In-order instruction store; each stage must finish its instructions in queue order
`timescale 1ns/1ps

module vinsn_queue (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  vmul_types_pkg::vinsn_t insn_i,
  input  logic                   insn_valid_i,
  output logic                   ready_o,
  output vmul_types_pkg::vinsn_t issue_insn_o,
  output logic                   issue_valid_o,
  input  logic                   issue_done_i,
  output vmul_types_pkg::vinsn_t proc_insn_o,
  output logic                   proc_valid_o,
  input  logic                   proc_done_i,
  output vmul_types_pkg::vinsn_t commit_insn_o,
  output logic                   commit_valid_o,
  input  logic                   commit_done_i
);

  localparam int unsigned Depth = vmul_cfg_pkg::VInsnQueueDepth;
  localparam int unsigned PtrW  = $clog2(Depth);

  vmul_types_pkg::vinsn_t insn_q [Depth];

  logic [PtrW-1:0] accept_pnt_q, issue_pnt_q, proc_pnt_q, commit_pnt_q;
  logic [PtrW:0]   issue_cnt_q, proc_cnt_q, commit_cnt_q;
  logic            accept;

  function automatic logic [PtrW:0] bump(
    input logic [PtrW:0] cnt,
    input logic          inc,
    input logic          dec
  );
    return cnt + (PtrW+1)'(inc) - (PtrW+1)'(dec);
  endfunction

  // An instruction stays counted until its last result is granted
  assign ready_o = (commit_cnt_q != (PtrW+1)'(Depth));
  assign accept  = insn_valid_i && ready_o;

  assign issue_insn_o   = insn_q[issue_pnt_q];
  assign issue_valid_o  = (issue_cnt_q != '0);
  assign proc_insn_o    = insn_q[proc_pnt_q];
  assign proc_valid_o   = (proc_cnt_q != '0);
  assign commit_insn_o  = insn_q[commit_pnt_q];
  assign commit_valid_o = (commit_cnt_q != '0);

  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_q[accept_pnt_q] <= insn_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      proc_pnt_q   <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      proc_cnt_q   <= '0;
      commit_cnt_q <= '0;
    end else begin
      // Pointers wrap on their own since the depth is a power of two
      if (accept) begin
        accept_pnt_q <= accept_pnt_q + PtrW'(1);
      end
      if (issue_done_i) begin
        issue_pnt_q <= issue_pnt_q + PtrW'(1);
      end
      if (proc_done_i) begin
        proc_pnt_q <= proc_pnt_q + PtrW'(1);
      end
      if (commit_done_i) begin
        commit_pnt_q <= commit_pnt_q + PtrW'(1);
      end
      issue_cnt_q  <= bump(issue_cnt_q, accept, issue_done_i);
      proc_cnt_q   <= bump(proc_cnt_q, accept, proc_done_i);
      commit_cnt_q <= bump(commit_cnt_q, accept, commit_done_i);
    end
  end

endmodule

//--- src/vmul_cfg_pkg.sv
// Lane configuration; queue depths must be powers of two and one register holds RegWords words
package vmul_cfg_pkg;

  // Data word and its byte enables
  localparam int unsigned ElenWidth = 64;
  localparam int unsigned StrbWidth = ElenWidth / 8;

  // Instructions in flight and result buffering
  localparam int unsigned VInsnQueueDepth  = 4;
  localparam int unsigned ResultQueueDepth = 2;

  localparam int unsigned NrVInsn  = 8;
  localparam int unsigned VidWidth = $clog2(NrVInsn);

  // Vector length and register layout inside this lane
  localparam int unsigned VlWidth    = 8;
  localparam int unsigned RegWords   = 16;
  localparam int unsigned VaddrWidth = 7;
  localparam int unsigned VdWidth    = VaddrWidth - $clog2(RegWords);

  localparam int unsigned MulLatencyDefault = 2;

endpackage

//--- src/vmul_types_pkg.sv
// Instruction encodings; vl must be nonzero and no larger than one register can hold
package vmul_types_pkg;

  typedef enum logic [1:0] {
    VMUL  = 2'd0,
    VMULH = 2'd1,
    VMACC = 2'd2
  } vmul_op_e;

  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // One instruction as held in the instruction queue
  typedef struct packed {
    vmul_op_e                           op;
    vew_e                               vew;
    logic [vmul_cfg_pkg::VlWidth-1:0]   vl;
    logic [vmul_cfg_pkg::VdWidth-1:0]   vd;
    logic [vmul_cfg_pkg::VidWidth-1:0]  id;
    logic                               use_scalar;
    logic [vmul_cfg_pkg::ElenWidth-1:0] scalar;
  } vinsn_t;

  // Elements in one word, clamped at the elements still left
  function automatic logic [vmul_cfg_pkg::VlWidth-1:0] word_elems(
    input vew_e                             vew,
    input logic [vmul_cfg_pkg::VlWidth-1:0] remaining
  );
    logic [vmul_cfg_pkg::VlWidth-1:0] per_word;
    per_word      = '0;
    per_word[3:0] = 4'd8 >> vew;
    return (per_word > remaining) ? remaining : per_word;
  endfunction

endpackage

//--- src/vmul_unit.sv
// Integer multiply unit for one lane; no masking and all results go to the VRF in order
`timescale 1ns/1ps

module vmul_unit #(
  parameter int unsigned MulLatency = vmul_cfg_pkg::MulLatencyDefault
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    op_valid_i,
  input  vmul_types_pkg::vmul_op_e                op_i,
  input  vmul_types_pkg::vew_e                    vew_i,
  input  logic [vmul_cfg_pkg::VlWidth-1:0]        vl_i,
  input  logic [vmul_cfg_pkg::VdWidth-1:0]        vd_i,
  input  logic [vmul_cfg_pkg::VidWidth-1:0]       id_i,
  input  logic                                    use_scalar_i,
  input  logic [vmul_cfg_pkg::ElenWidth-1:0]      scalar_i,
  output logic                                    ready_o,
  input  logic [2:0][vmul_cfg_pkg::ElenWidth-1:0] operand_i,
  input  logic [2:0]                              operand_valid_i,
  output logic [2:0]                              operand_ready_o,
  output logic                                    result_req_o,
  output logic [vmul_cfg_pkg::VidWidth-1:0]       result_id_o,
  output logic [vmul_cfg_pkg::VaddrWidth-1:0]     result_addr_o,
  output logic [vmul_cfg_pkg::ElenWidth-1:0]      result_wdata_o,
  output logic [vmul_cfg_pkg::StrbWidth-1:0]      result_be_o,
  input  logic                                    result_gnt_i,
  output logic [vmul_cfg_pkg::NrVInsn-1:0]        vinsn_done_o
);

  vmul_types_pkg::vinsn_t             insn, issue_insn, proc_insn, commit_insn;
  logic                               issue_valid, issue_done;
  logic                               proc_valid, proc_done;
  logic                               commit_valid, commit_done;
  logic [vmul_cfg_pkg::ElenWidth-1:0] mul_result;
  logic                               mul_valid, mul_ready;

  mul_req_if mul_bus ();

  assign insn = '{
    op:         op_i,
    vew:        vew_i,
    vl:         vl_i,
    vd:         vd_i,
    id:         id_i,
    use_scalar: use_scalar_i,
    scalar:     scalar_i
  };

  vinsn_queue i_vinsn_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .insn_i         (insn),
    .insn_valid_i   (op_valid_i),
    .ready_o        (ready_o),
    .issue_insn_o   (issue_insn),
    .issue_valid_o  (issue_valid),
    .issue_done_i   (issue_done),
    .proc_insn_o    (proc_insn),
    .proc_valid_o   (proc_valid),
    .proc_done_i    (proc_done),
    .commit_insn_o  (commit_insn),
    .commit_valid_o (commit_valid),
    .commit_done_i  (commit_done)
  );

  mul_issue i_mul_issue (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .insn_i          (issue_insn),
    .insn_valid_i    (issue_valid),
    .done_o          (issue_done),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_ready_o (operand_ready_o),
    .mul             (mul_bus)
  );

  simd_mul #(
    .MulLatency (MulLatency)
  ) i_simd_mul (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req      (mul_bus),
    .result_o (mul_result),
    .valid_o  (mul_valid),
    .ready_i  (mul_ready)
  );

  result_stage i_result_stage (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .result_i       (mul_result),
    .valid_i        (mul_valid),
    .ready_o        (mul_ready),
    .proc_insn_i    (proc_insn),
    .proc_valid_i   (proc_valid),
    .proc_done_o    (proc_done),
    .commit_insn_i  (commit_insn),
    .commit_valid_i (commit_valid),
    .commit_done_o  (commit_done),
    .vinsn_done_o   (vinsn_done_o),
    .result_req_o   (result_req_o),
    .result_id_o    (result_id_o),
    .result_addr_o  (result_addr_o),
    .result_wdata_o (result_wdata_o),
    .result_be_o    (result_be_o),
    .result_gnt_i   (result_gnt_i)
  );

endmodule

//--- tb/tb_vmul_unit.sv
// Testbench for vmul_unit; default multiplier latency, operand valid gaps only in the random test
`timescale 1ns/1ps

module tb_vmul_unit;

  localparam int NumTests = 6;
  localparam int NumRows  = 25;
  localparam int Timeout  = 2000;

  typedef struct packed {
    logic [3:0] test;
    logic [1:0] op;
    logic [1:0] vew;
    logic [7:0] vl;
    logic [2:0] vd;
    logic       us;
  } row_t;

  // Test, op, width code, vl, vd, use-scalar
  row_t insn_tab [NumRows] = '{
    '{4'd0, 2'd0, 2'd0, 8'd16, 3'd1, 1'b0}, '{4'd0, 2'd0, 2'd1, 8'd8, 3'd2, 1'b0},
    '{4'd0, 2'd0, 2'd2, 8'd4, 3'd3, 1'b0},  '{4'd0, 2'd0, 2'd3, 8'd2, 3'd4, 1'b0},
    '{4'd1, 2'd0, 2'd0, 8'd16, 3'd5, 1'b1}, '{4'd1, 2'd0, 2'd1, 8'd8, 3'd6, 1'b1},
    '{4'd1, 2'd0, 2'd2, 8'd4, 3'd7, 1'b1},  '{4'd1, 2'd0, 2'd3, 8'd2, 3'd0, 1'b1},
    '{4'd2, 2'd1, 2'd1, 8'd8, 3'd1, 1'b0},  '{4'd2, 2'd1, 2'd3, 8'd2, 3'd2, 1'b0},
    '{4'd2, 2'd2, 2'd1, 8'd8, 3'd3, 1'b0},  '{4'd2, 2'd2, 2'd3, 8'd2, 3'd4, 1'b0},
    '{4'd3, 2'd0, 2'd0, 8'd13, 3'd5, 1'b0}, '{4'd3, 2'd0, 2'd1, 8'd7, 3'd6, 1'b0},
    '{4'd3, 2'd2, 2'd2, 8'd5, 3'd7, 1'b1},  '{4'd3, 2'd1, 2'd3, 8'd3, 3'd1, 1'b0},
    '{4'd4, 2'd0, 2'd0, 8'd20, 3'd2, 1'b0}, '{4'd4, 2'd2, 2'd1, 8'd9, 3'd3, 1'b0},
    '{4'd4, 2'd1, 2'd2, 8'd6, 3'd4, 1'b1},  '{4'd4, 2'd0, 2'd3, 8'd4, 3'd5, 1'b0},
    '{4'd5, 2'd0, 2'd1, 8'd8, 3'd1, 1'b0},  '{4'd5, 2'd2, 2'd0, 8'd16, 3'd2, 1'b0},
    '{4'd5, 2'd1, 2'd2, 8'd4, 3'd3, 1'b0},  '{4'd5, 2'd0, 2'd3, 8'd3, 3'd4, 1'b1},
    '{4'd5, 2'd2, 2'd2, 8'd6, 3'd5, 1'b0}
  };

  // Grant mode 0 always grants, 1 leaves random gaps in grants and operand valids,
  // 2 holds grants until ready_o drops
  int seed_off [NumTests]   = '{0, 11, 22, 33, 44, 55};
  int grant_mode [NumTests] = '{0, 0, 0, 0, 1, 2};

  logic             clk_i, rst_ni, op_valid_i, use_scalar_i, ready_o, result_gnt_i;
  logic [1:0]       op_i, vew_i;
  logic [7:0]       vl_i, vinsn_done_o;
  logic [2:0]       vd_i, id_i, operand_valid_i, operand_ready_o, result_id_o;
  logic [63:0]      scalar_i, result_wdata_o;
  logic [2:0][63:0] operand_i;
  logic             result_req_o;
  logic [6:0]       result_addr_o;
  logic [7:0]       result_be_o;

  logic [31:0] op_state, ins_state;
  logic [2:0]  rdy_seen;
  int          mode, hold_grant, done_total, tb_errors, next_id;

  vmul_unit DUT (
    .clk_i, .rst_ni, .op_valid_i,
    .op_i (vmul_types_pkg::vmul_op_e'(op_i)),
    .vew_i (vmul_types_pkg::vew_e'(vew_i)),
    .vl_i, .vd_i, .id_i, .use_scalar_i, .scalar_i, .ready_o,
    .operand_i, .operand_valid_i, .operand_ready_o,
    .result_req_o, .result_id_o, .result_addr_o, .result_wdata_o, .result_be_o,
    .result_gnt_i, .vinsn_done_o
  );

  vmul_checker chk (.*);

  // Errors from the testbench, the checker and the bound assertions
  function automatic int error_count();
    return tb_errors + chk.errors + DUT.i_vmul_properties.failures;
  endfunction

  function automatic logic [31:0] lcg_next(inout logic [31:0] state);
    state = state * 32'd1103515245 + 32'd12345;
    return state;
  endfunction

  function automatic logic [63:0] rand_word(inout logic [31:0] state);
    logic [31:0] hi, lo;
    hi = lcg_next(state);
    lo = lcg_next(state);
    return {hi, lo};
  endfunction

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    rdy_seen = operand_ready_o;
    if (vinsn_done_o != '0) begin
      done_total++;
    end
  end

  // Operand words and grants; a word changes only after it was taken
  always @(negedge clk_i) begin : drive_side
    logic [31:0] r;
    if (rst_ni) begin
      for (int k = 0; k < 3; k++) begin
        if (rdy_seen[k]) begin
          operand_i[k] = rand_word(op_state);
        end
      end
      r = lcg_next(op_state);
      operand_valid_i = 3'b111;
      case (mode)
        1: begin
          result_gnt_i = (r[31:30] != 2'b00);
          for (int k = 0; k < 3; k++) begin
            operand_valid_i[k] = (r[23+2*k +: 2] != 2'b00);
          end
        end
        2:       result_gnt_i = (hold_grant == 0);
        default: result_gnt_i = 1'b1;
      endcase
    end
  end

  task automatic send_insn(input row_t row, inout int accepted);
    bit ok;
    @(negedge clk_i);
    op_valid_i   = 1'b1;
    op_i         = row.op;
    vew_i        = row.vew;
    vl_i         = row.vl;
    vd_i         = row.vd;
    id_i         = 3'(next_id);
    use_scalar_i = row.us;
    scalar_i     = rand_word(ins_state);
    ok = 1'b0;
    for (int cyc = 0; cyc < Timeout && !ok; cyc++) begin
      @(posedge clk_i);
      ok = ready_o;
    end
    if (!ok) begin
      tb_errors++;
      $display("Timeout at %0t ns: instruction %0d was never accepted", $time, next_id);
    end
    next_id++;
    accepted++;
    // All four slots are taken now, so new instructions must be refused
    if (mode == 2 && accepted == 4) begin
      @(negedge clk_i);
      op_valid_i = 1'b0;
      if (ready_o !== 1'b0) begin
        tb_errors++;
        $display("ready_o stayed high at %0t ns with four instructions held", $time);
      end
      @(posedge clk_i);
      hold_grant = 0;
    end
  endtask

  task automatic run_test(input int t, inout int failed);
    int n, accepted, done_start, err_start;
    n        = 0;
    accepted = 0;
    @(posedge clk_i);
    op_state   = 32'd86 + 32'(seed_off[t]);
    ins_state  = 32'd86 + 32'(seed_off[t]) + 32'd1000;
    mode       = grant_mode[t];
    hold_grant = (mode == 2);
    done_start = done_total;
    err_start  = error_count();
    for (int r = 0; r < NumRows; r++) begin
      if (insn_tab[r].test == t) begin
        send_insn(insn_tab[r], accepted);
        n++;
      end
    end
    @(negedge clk_i);
    op_valid_i = 1'b0;
    for (int cyc = 0; cyc < Timeout && done_total - done_start < n; cyc++) begin
      @(negedge clk_i);
    end
    if (done_total - done_start != n) begin
      tb_errors++;
      $display("Timeout in test %0d: %0d of %0d instructions finished", t,
               done_total - done_start, n);
    end else if (chk.pending() != 0) begin
      tb_errors++;
      $display("Test %0d finished with %0d results still expected", t, chk.pending());
    end
    if (error_count() != err_start) begin
      failed++;
    end
    $display("Test %0d: %0d instructions, %0d errors", t, n, error_count() - err_start);
  endtask

  initial begin
    int failed;
    failed          = 0;
    tb_errors       = 0;
    done_total      = 0;
    next_id         = 0;
    mode            = 0;
    hold_grant      = 0;
    rdy_seen        = '0;
    rst_ni          = 1'b0;
    op_valid_i      = 1'b0;
    op_i            = '0;
    vew_i           = '0;
    vl_i            = '0;
    vd_i            = '0;
    id_i            = '0;
    use_scalar_i    = 1'b0;
    scalar_i        = '0;
    op_state        = 32'd86;
    ins_state       = 32'd86;
    operand_i       = '0;
    operand_valid_i = 3'b111;
    result_gnt_i    = 1'b0;
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;
    for (int t = 0; t < NumTests; t++) begin
      run_test(t, failed);
    end
    $display("Summary: %0d tests, %0d failed, %0d errors, %0d grants", NumTests, failed,
             error_count(), chk.grants);
    if (failed == 0 && error_count() == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- tb/vmul_checker.sv
// Reference model of the multiply unit; expects every element active and results granted in order
`timescale 1ns/1ps

module vmul_checker (
  input logic             clk_i,
  input logic             rst_ni,
  input logic             op_valid_i,
  input logic [1:0]       op_i,
  input logic [1:0]       vew_i,
  input logic [7:0]       vl_i,
  input logic [2:0]       vd_i,
  input logic [2:0]       id_i,
  input logic             use_scalar_i,
  input logic [63:0]      scalar_i,
  input logic             ready_o,
  input logic [2:0][63:0] operand_i,
  input logic [2:0]       operand_ready_o,
  input logic             result_req_o,
  input logic [2:0]       result_id_o,
  input logic [6:0]       result_addr_o,
  input logic [63:0]      result_wdata_o,
  input logic [7:0]       result_be_o,
  input logic             result_gnt_i,
  input logic [7:0]       vinsn_done_o
);

  typedef struct packed {
    logic [1:0]  op;
    logic [1:0]  vew;
    logic [7:0]  vl;
    logic [2:0]  vd;
    logic [2:0]  id;
    logic        us;
    logic [63:0] scalar;
  } insn_t;

  typedef struct packed {
    logic [2:0]  id;
    logic [6:0]  addr;
    logic [63:0] data;
    logic [7:0]  be;
    logic        last;
  } exp_t;

  insn_t insn_q [$];
  exp_t  exp_q  [$];
  int    done_elems;
  int    errors = 0;
  int    grants = 0;

  // Element-wise product of one word, width 8 << vew
  function automatic logic [63:0] ref_word(input logic [1:0] op, input logic [1:0] vew,
                                           input logic [63:0] a, input logic [63:0] b,
                                           input logic [63:0] c);
    int                   w;
    logic [63:0]          mask, ea, eb, ec, r, word;
    logic signed [63:0]   xa, xb;
    logic signed [127:0]  pa, pb, p;
    w    = 8 << vew;
    mask = (w == 64) ? '1 : (64'd1 << w) - 64'd1;
    word = '0;
    for (int i = 0; i < 64 / w; i++) begin
      ea = (a >> (i * w)) & mask;
      eb = (b >> (i * w)) & mask;
      ec = (c >> (i * w)) & mask;
      xa = $signed(ea << (64 - w)) >>> (64 - w);
      xb = $signed(eb << (64 - w)) >>> (64 - w);
      pa = xa;
      pb = xb;
      p  = pa * pb;
      case (op)
        2'd1:    r = 64'(p >>> w);
        2'd2:    r = p[63:0] + ec;
        default: r = p[63:0];
      endcase
      word = word | ((r & mask) << (i * w));
    end
    return word;
  endfunction

  function automatic logic [63:0] replicate(input logic [63:0] s, input logic [1:0] vew);
    int          w;
    logic [63:0] mask, word;
    w    = 8 << vew;
    mask = (w == 64) ? '1 : (64'd1 << w) - 64'd1;
    word = '0;
    for (int i = 0; i < 64 / w; i++) begin
      word = word | ((s & mask) << (i * w));
    end
    return word;
  endfunction

  task automatic compare(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %0t ns: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
    end
  endtask

  function automatic int pending();
    return exp_q.size() + insn_q.size();
  endfunction

  always @(posedge clk_i) begin : model
    insn_t       cur;
    exp_t        e;
    int          epw, n, bytes;
    logic [63:0] a, bmask;
    logic [2:0]  need;
    if (!rst_ni) begin
      insn_q.delete();
      exp_q.delete();
      done_elems = 0;
    end else begin
      // Every micro-operation takes vs2, vs1 unless a scalar is used, vd only for VMACC
      if (operand_ready_o != 3'b000) begin
        if (insn_q.size() == 0) begin
          errors++;
          $display("Operand transfer at %0t ns with no instruction outstanding", $time);
        end else begin
          cur  = insn_q[0];
          need = 3'b010;
          if (!cur.us) begin
            need[0] = 1'b1;
          end
          if (cur.op == 2'd2) begin
            need[2] = 1'b1;
          end
          compare("operand acknowledge", 64'(operand_ready_o), 64'(need));
          epw   = 8 >> cur.vew;
          bytes = 1 << cur.vew;
          n     = (cur.vl - done_elems < epw) ? cur.vl - done_elems : epw;
          a     = cur.us ? replicate(cur.scalar, cur.vew) : operand_i[0];
          e.id   = cur.id;
          e.addr = 7'(cur.vd * 16 + done_elems / epw);
          e.data = ref_word(cur.op, cur.vew, a, operand_i[1], operand_i[2]);
          e.be   = 8'((1 << (n * bytes)) - 1);
          e.last = (done_elems + n == cur.vl);
          exp_q.push_back(e);
          done_elems += n;
          if (e.last) begin
            void'(insn_q.pop_front());
            done_elems = 0;
          end
        end
      end
      if (result_req_o && result_gnt_i) begin
        grants++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("Grant at %0t ns for a result that was never issued", $time);
        end else begin
          e = exp_q.pop_front();
          for (int i = 0; i < 8; i++) begin
            bmask[8*i +: 8] = {8{e.be[i]}};
          end
          compare("result id", 64'(result_id_o), 64'(e.id));
          compare("result address", 64'(result_addr_o), 64'(e.addr));
          compare("byte enables", 64'(result_be_o), 64'(e.be));
          compare("write data", result_wdata_o & bmask, e.data & bmask);
          compare("done bits", 64'(vinsn_done_o), e.last ? 64'(1) << e.id : 64'd0);
        end
      end else begin
        compare("done bits without grant", 64'(vinsn_done_o), 64'd0);
      end
      if (op_valid_i && ready_o) begin
        insn_q.push_back('{op_i, vew_i, vl_i, vd_i, id_i, use_scalar_i, scalar_i});
      end
    end
  end

endmodule

//--- tb/vmul_properties.sv
// Handshake assertions bound into vmul_unit; they assume reset is released on a falling edge
`timescale 1ns/1ps

module vmul_properties (
  input logic        clk_i,
  input logic        rst_ni,
  input logic        ready_o,
  input logic [2:0]  operand_valid_i,
  input logic [2:0]  operand_ready_o,
  input logic        result_req_o,
  input logic [2:0]  result_id_o,
  input logic [6:0]  result_addr_o,
  input logic [63:0] result_wdata_o,
  input logic [7:0]  result_be_o,
  input logic        result_gnt_i,
  input logic [7:0]  vinsn_done_o
);

  int failures = 0;

  // Request and payload hold until granted
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_req_o && !result_gnt_i |=> result_req_o &&
      $stable({result_id_o, result_addr_o, result_wdata_o, result_be_o}))
    else begin
      failures++;
      $error("result request dropped or changed before its grant");
    end

  // At most one done bit, and only the one of the id being granted
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(vinsn_done_o) &&
      (vinsn_done_o == '0 || (result_req_o && result_gnt_i && vinsn_done_o[result_id_o])))
    else begin
      failures++;
      $error("more than one instruction done bit set, or a bit away from the granted id");
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (operand_ready_o & ~operand_valid_i) == 3'b000)
    else begin
      failures++;
      $error("operand acknowledged while its queue was not valid");
    end

  assert property (@(posedge clk_i) $rose(rst_ni) |-> ready_o)
    else begin
      failures++;
      $error("ready_o low right after reset");
    end

endmodule

bind vmul_unit vmul_properties i_vmul_properties (.*);
